//--- files.f
+incdir+design
design/memPkg.sv
design/reqArbiter.sv
design/byteSequencer.sv
design/respAssembler.sv
design/memSubsystem.sv
verif/memTb.sv

//--- Bender.yml
package:
  name: memSubsystem

sources:
  - include_dirs:
      - design
    files:
      - design/memPkg.sv
      - design/reqArbiter.sv
      - design/byteSequencer.sv
      - design/respAssembler.sv
      - design/memSubsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/memTb.sv

//--- verif/memTb.sv
`timescale 1ns/1ps
`include "memCfg.svh"

module memTb
    import memPkg::*;
;

    // about 300 transactions at up to 20 cycles each
    localparam int cycleLimit = 6000;

    typedef struct packed {
        logic                   isLoad;
        logic [`MEM_WORD_W-1:0] value;
    } dataExp_t;

    logic clk;
    logic rst;
    logic fetchEn;
    logic [`MEM_ADDR_W-1:0] fetchAddr;
    logic fetchDone;
    logic [`MEM_WORD_W-1:0] fetchInst;
    logic dataEn;
    logic dataStore;
    logic [`MEM_LEN_W-1:0] dataLen;
    logic [`MEM_ADDR_W-1:0] dataAddr;
    logic [`MEM_WORD_W-1:0] dataWdata;
    logic dataDone;
    logic [`MEM_WORD_W-1:0] dataRdata;
    ramPort_t ramBus;
    logic [`MEM_BYTE_W-1:0] ramRdata;
    logic ioBufferFull;
    logic rdy;
    owner_t owner;

    logic [`MEM_BYTE_W-1:0] ramMem [0:4095];
    logic [`MEM_BYTE_W-1:0] shadow [0:4095];
    logic [`MEM_WORD_W-1:0] fetchQ [$];
    dataExp_t dataQ [$];
    logic [`MEM_ADDR_W-1:0] storeAddr [$];
    logic [`MEM_LEN_W-1:0] storeLen [$];

    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int testErrStart = 0;
    int stallCount = 0;
    logic stallOn = 1'b0;

    memSubsystem memSubsystem_i (
        .clk          (clk),
        .rst          (rst),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .ram          (ramBus),
        .ramRdata     (ramRdata),
        .ioBufferFull (ioBufferFull),
        .rdy          (rdy),
        .owner        (owner)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // byte ram, read data one cycle after the address
    always @(posedge clk) begin
        if (ramBus.we) begin
            ramMem[ramBus.addr[11:0]] <= ramBus.wdata;
        end
        ramRdata <= ramMem[ramBus.addr[11:0]];
    end

    // random stalls, counted only while a transaction holds the ram
    always @(posedge clk) begin
        #1;
        if (stallOn) begin
            ioBufferFull = ($urandom % 5) == 0;
            rdy          = ($urandom % 4) != 0;
        end else begin
            ioBufferFull = 1'b0;
            rdy          = 1'b1;
        end
        if (owner != ownIdle && (ioBufferFull || !rdy)) begin
            stallCount++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [7:0] fillByte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    // little endian, upper bytes zero
    function automatic logic [31:0] refValue(input logic [31:0] addr, input logic [2:0] len);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < len; i++) begin
            v[8*i +: 8] = shadow[addr[11:0] + i];
        end
        return v;
    endfunction

    function automatic logic [2:0] pickLen();
        case ($urandom % 3)
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // compare each response against the queued expectation
    always @(negedge clk) begin
        if (!rst && fetchDone) begin
            if (fetchQ.size() == 0) begin
                errors++;
                $display("Error at %0t: fetchDone without an outstanding fetch", $time);
            end else begin
                checkValue(fetchInst, fetchQ.pop_front(), "fetch word");
            end
        end
        if (!rst && dataDone) begin
            if (dataQ.size() == 0) begin
                errors++;
                $display("Error at %0t: dataDone without an outstanding data request", $time);
            end else begin
                if (dataQ[0].isLoad) begin
                    checkValue(dataRdata, dataQ[0].value, "load value");
                end
                void'(dataQ.pop_front());
            end
        end
    end

    task automatic awaitDone(input logic isFetch, output int edges);
        edges = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (isFetch ? !fetchDone : !dataDone);
    endtask

    task automatic fetchWord(input logic [31:0] addr);
        int edges;
        @(posedge clk);
        #1;
        fetchQ.push_back(refValue(addr, 3'd4));
        fetchEn    = 1'b1;
        fetchAddr  = addr;
        stallCount = 0;
        awaitDone(1'b1, edges);
        fetchEn = 1'b0;
        checkValue(edges - 1, `FETCH_BYTES + 1 + stallCount, "fetch latency");
    endtask

    task automatic accessData(input logic store, input logic [2:0] len, input logic [31:0] addr,
                              input logic [31:0] wdata);
        dataExp_t exp;
        int edges;
        int i;
        @(posedge clk);
        #1;
        exp.isLoad = !store;
        exp.value  = store ? '0 : refValue(addr, len);
        if (store) begin
            for (i = 0; i < len; i++) begin
                shadow[addr[11:0] + i] = wdata[8*i +: 8];
            end
            storeAddr.push_back(addr);
            storeLen.push_back(len);
        end
        dataQ.push_back(exp);
        dataEn     = 1'b1;
        dataStore  = store;
        dataLen    = len;
        dataAddr   = addr;
        dataWdata  = wdata;
        stallCount = 0;
        awaitDone(1'b0, edges);
        dataEn = 1'b0;
        checkValue(edges - 1, len + 1 + stallCount, "data latency");
    endtask

    task automatic collideRequests(input logic [31:0] faddr, input logic [31:0] daddr,
                                   input logic [2:0] len);
        dataExp_t exp;
        int edges;
        @(posedge clk);
        #1;
        exp.isLoad = 1'b1;
        exp.value  = refValue(daddr, len);
        dataQ.push_back(exp);
        fetchQ.push_back(refValue(faddr, 3'd4));
        fetchEn   = 1'b1;
        fetchAddr = faddr;
        dataEn    = 1'b1;
        dataStore = 1'b0;
        dataLen   = len;
        dataAddr  = daddr;
        @(posedge clk);
        #1;
        checkValue(32'(owner), 32'(ownData), "owner after collision");
        while (!dataDone) begin
            if (fetchDone) begin
                errors++;
                $display("Error at %0t: fetch finished ahead of the data request", $time);
            end
            @(posedge clk);
            #1;
        end
        dataEn = 1'b0;
        awaitDone(1'b1, edges);
        fetchEn = 1'b0;
    endtask

    task automatic finishTest(input string name);
        @(negedge clk);
        #1;
        tests++;
        $display("test %s: %0d errors", name, errors - testErrStart);
        testErrStart = errors;
    endtask

    initial begin
        int i;
        int n;
        void'($urandom(32'ha459));
        rst          = 1'b1;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = 3'd1;
        dataAddr     = '0;
        dataWdata    = '0;
        ramRdata     = '0;
        ioBufferFull = 1'b0;
        rdy          = 1'b1;
        for (i = 0; i < 4096; i++) begin
            ramMem[i] = fillByte(i[11:0]);
            shadow[i] = fillByte(i[11:0]);
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        checkValue(fetchDone, 1'b0, "fetchDone after reset");
        checkValue(dataDone, 1'b0, "dataDone after reset");
        checkValue(ramBus.we, 1'b0, "write strobe after reset");
        checkValue(32'(owner), 32'(ownIdle), "owner after reset");
        finishTest("reset");

        for (i = 0; i < 20; i++) begin
            fetchWord(($urandom % 1024) * 4);
        end
        finishTest("fetch");

        for (i = 0; i < 30; i++) begin
            accessData(1'b0, (i % 3 == 0) ? 3'd1 : ((i % 3 == 1) ? 3'd2 : 3'd4),
                       $urandom % 4093, '0);
        end
        finishTest("load");

        for (i = 0; i < 30; i++) begin
            accessData(1'b1, pickLen(), $urandom % 4093, $urandom);
        end
        n = storeAddr.size();
        for (i = 0; i < n; i++) begin
            accessData(1'b0, storeLen[i], storeAddr[i], '0);
            if (i % 3 == 0) begin
                fetchWord(storeAddr[i] & 32'hffff_fffc);
            end
        end
        finishTest("store and readback");

        for (i = 0; i < 5; i++) begin
            collideRequests(($urandom % 1024) * 4, $urandom % 4093, pickLen());
        end
        finishTest("arbitration");

        stallOn = 1'b1;
        for (i = 0; i < 60; i++) begin
            case ($urandom % 3)
                0: fetchWord(($urandom % 1024) * 4);
                1: accessData(1'b0, pickLen(), $urandom % 4093, '0);
                default: accessData(1'b1, pickLen(), $urandom % 4093, $urandom);
            endcase
        end
        stallOn = 1'b0;
        finishTest("stalls");

        repeat (4) @(posedge clk);
        if (fetchQ.size() != 0 || dataQ.size() != 0) begin
            errors++;
            $display("Error: %0d responses never arrived", fetchQ.size() + dataQ.size());
        end
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- design/memSubsystem.sv
`timescale 1ns/1ps
`include "memCfg.svh"

module memSubsystem
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchEn,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    output logic                   fetchDone,
    output logic [`MEM_WORD_W-1:0] fetchInst,
    input  logic                   dataEn,
    input  logic                   dataStore,
    input  logic [`MEM_LEN_W-1:0]  dataLen,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  logic [`MEM_WORD_W-1:0] dataWdata,
    output logic                   dataDone,
    output logic [`MEM_WORD_W-1:0] dataRdata,
    output ramPort_t               ram,
    input  logic [`MEM_BYTE_W-1:0] ramRdata,
    input  logic                   ioBufferFull,
    input  logic                   rdy,
    output owner_t                 owner
);

    logic     pendValid;
    memReq_t  pendReq;
    logic     take;
    logic     finish;
    capture_t cap;

    reqArbiter reqArbiter_i (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .take      (take),
        .finish    (finish),
        .pendValid (pendValid),
        .pendReq   (pendReq),
        .owner     (owner)
    );

    byteSequencer byteSequencer_i (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .rdy          (rdy),
        .pendValid    (pendValid),
        .pendReq      (pendReq),
        .take         (take),
        .finish       (finish),
        .ram          (ram),
        .cap          (cap)
    );

    respAssembler respAssembler_i (
        .clk       (clk),
        .rst       (rst),
        .cap       (cap),
        .ramRdata  (ramRdata),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

endmodule

//--- design/respAssembler.sv
`timescale 1ns/1ps
`include "memCfg.svh"

module respAssembler
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  capture_t               cap,
    input  logic [`MEM_BYTE_W-1:0] ramRdata,
    output logic                   fetchDone,
    output logic [`MEM_WORD_W-1:0] fetchInst,
    output logic                   dataDone,
    output logic [`MEM_WORD_W-1:0] dataRdata
);

    capture_t capQ;

    logic [`MEM_WORD_W-1:0] hold;
    logic [`MEM_WORD_W-1:0] merged;
    logic [`MEM_WORD_W-1:0] fetchHeld;
    logic [`MEM_WORD_W-1:0] dataHeld;
    logic                   wordEnd;
    logic                   loadEnd;

    // lines up with the byte now on ramRdata
    always_ff @(posedge clk) begin
        if (rst) begin
            capQ <= '0;
        end else begin
            capQ <= cap;
        end
    end

    // lane zero starts a fresh word, upper lanes stay zero
    always_comb begin
        merged = (capQ.idx == 2'd0) ? '0 : hold;
        merged[capQ.idx*`MEM_BYTE_W +: `MEM_BYTE_W] = ramRdata;
    end

    assign wordEnd   = capQ.valid && capQ.last;
    assign loadEnd   = wordEnd && (capQ.kind == kindLoad);
    assign fetchDone = wordEnd && (capQ.kind == kindFetch);
    assign dataDone  = wordEnd && (capQ.kind != kindFetch);

    // result shows in the done cycle and stays until the next one
    assign fetchInst = fetchDone ? merged : fetchHeld;
    assign dataRdata = loadEnd ? merged : dataHeld;

    always_ff @(posedge clk) begin
        if (capQ.valid && capQ.kind != kindStore) begin
            hold <= merged;
        end
        if (fetchDone) begin
            fetchHeld <= merged;
        end
        if (loadEnd) begin
            dataHeld <= merged;
        end
    end

    // one owner at a time, so the pulses never overlap or stretch
    donePulse: assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |-> !(fetchDone && dataDone) ##1 !(fetchDone || dataDone));

endmodule

//--- design/byteSequencer.sv
`timescale 1ns/1ps
`include "memCfg.svh"

module byteSequencer
    import memPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ioBufferFull,
    input  logic     rdy,
    input  logic     pendValid,
    input  memReq_t  pendReq,
    output logic     take,
    output logic     finish,
    output ramPort_t ram,
    output capture_t cap
);

    seqState_t state;
    memReq_t   cur;

    logic [`MEM_LEN_W-1:0] idx;
    logic [`MEM_LEN_W-1:0] idxNext;
    logic                  stall;
    logic                  lastByte;

    // whole machine freezes on either condition
    assign stall = ioBufferFull || !rdy;

    assign idxNext  = idx + 1'b1;
    assign lastByte = (idxNext == cur.len);

    assign take   = (state == seqIdle) && pendValid && !stall;
    assign finish = (state == seqIssue) && !stall && lastByte;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            idx   <= '0;
        end else begin
            case (state)
                seqIdle: begin
                    if (take) begin
                        state <= seqIssue;
                        idx   <= '0;
                    end
                end
                seqIssue: begin
                    if (!stall) begin
                        if (lastByte) begin
                            state <= seqIdle;
                        end else begin
                            idx <= idxNext;
                        end
                    end
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    // request copy, held for the whole transaction
    always_ff @(posedge clk) begin
        if (take) begin
            cur <= pendReq;
        end
    end

    always_comb begin
        ram = '0;
        cap = '0;
        if (state == seqIssue) begin
            ram.addr  = cur.addr + {{(`MEM_ADDR_W-`MEM_LEN_W){1'b0}}, idx};
            ram.wdata = cur.wdata[idx[1:0]*`MEM_BYTE_W +: `MEM_BYTE_W];
            ram.we    = (cur.kind == kindStore) && !stall;
            // stores only report the last write
            cap.valid = !stall && ((cur.kind != kindStore) || lastByte);
            cap.idx   = idx[1:0];
            cap.last  = lastByte;
            cap.kind  = cur.kind;
        end
    end

    // a load or fetch taken here never writes before it finishes
    noReadWrite: assert property (@(posedge clk) disable iff (rst)
        (take && pendReq.kind != kindStore) |=> (!ram.we until_with finish));

    // no second take until the running transaction finishes
    singleTake: assert property (@(posedge clk) disable iff (rst)
        take |=> (!take until_with finish));

endmodule

//--- design/reqArbiter.sv
`timescale 1ns/1ps
`include "memCfg.svh"

module reqArbiter
    import memPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchEn,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    input  logic                   dataEn,
    input  logic                   dataStore,
    input  logic [`MEM_LEN_W-1:0]  dataLen,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  logic [`MEM_WORD_W-1:0] dataWdata,
    input  logic                   take,
    input  logic                   finish,
    output logic                   pendValid,
    output memReq_t                pendReq,
    output owner_t                 owner
);

    localparam logic [`MEM_LEN_W-1:0] fetchLen = `FETCH_BYTES;

    logic canLatch;

    // only one transaction in flight at a time
    assign canLatch = (owner == ownIdle) && !pendValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner     <= ownIdle;
            pendValid <= 1'b0;
        end else begin
            if (canLatch && dataEn) begin
                pendValid <= 1'b1;
                owner     <= ownData;
            end else if (canLatch && fetchEn) begin
                pendValid <= 1'b1;
                owner     <= ownFetch;
            end else if (take) begin
                pendValid <= 1'b0;
            end
            if (finish) begin
                owner <= ownIdle;
            end
        end
    end

    // data side wins when both ask in the same cycle
    always_ff @(posedge clk) begin
        if (canLatch) begin
            if (dataEn) begin
                pendReq.kind  <= dataStore ? kindStore : kindLoad;
                pendReq.addr  <= dataAddr;
                pendReq.len   <= dataLen;
                pendReq.wdata <= dataWdata;
            end else if (fetchEn) begin
                pendReq.kind  <= kindFetch;
                pendReq.addr  <= fetchAddr;
                pendReq.len   <= fetchLen;
                pendReq.wdata <= '0;
            end
        end
    end

    // sequencer must only finish a transaction this side handed out
    finishOwned: assert property (@(posedge clk) disable iff (rst)
        finish |-> owner != ownIdle);

    dataLenLegal: assert property (@(posedge clk) disable iff (rst)
        dataEn |-> dataLen inside {3'd1, 3'd2, 3'd4});

endmodule

//--- design/memPkg.sv
`include "memCfg.svh"

package memPkg;

    typedef enum logic [1:0] {
        kindFetch,
        kindLoad,
        kindStore
    } reqKind_t;

    typedef enum logic [1:0] {
        ownIdle,
        ownFetch,
        ownData
    } owner_t;

    typedef enum logic {
        seqIdle,
        seqIssue
    } seqState_t;

    typedef struct packed {
        reqKind_t               kind;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_LEN_W-1:0]  len;
        logic [`MEM_WORD_W-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_BYTE_W-1:0] wdata;
        logic                   we;
    } ramPort_t;

    // describes the byte the ram returns one cycle later
    typedef struct packed {
        logic       valid;
        logic [1:0] idx;
        logic       last;
        reqKind_t   kind;
    } capture_t;

endpackage

//--- design/memCfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// address and data word widths
`define MEM_ADDR_W 32
`define MEM_WORD_W 32

// ram is one byte wide
`define MEM_BYTE_W 8

// byte counts up to four
`define MEM_LEN_W 3
`define FETCH_BYTES 4

`endif
